// ==== src/drawPkg.sv ====
`default_nettype none

package drawPkg;

	// sram side widths
	typedef logic [19:0] sramAddr_t;
	typedef logic [15:0] sramWord_t;

	// frame store word index, 0 to 191
	typedef logic [7:0] frameIdx_t;
	// screen row, 0 to 47
	typedef logic [5:0] rowIdx_t;
	// four words per row, lowest word in the low bits
	typedef logic [63:0] bgRow_t;

	// bit 2 is the colour, bits 1:0 the direction (down, up, right, left)
	typedef logic [2:0] spriteIdx_t;
	typedef logic [6:0] spriteWordIdx_t;
	// sixteen words, word 0 in the low bits
	typedef logic [255:0] sprite_t;

	typedef enum logic [2:0] {
		MENU  = 3'd0,
		PLAY  = 3'd1,
		PAUSE = 3'd2,
		OVER  = 3'd3,
		WIN   = 3'd4
	} gameState_t;

	typedef enum logic [1:0] {
		LOAD_MENU,
		LOAD_BG,
		LOAD_SPRITES
	} loadKind_t;

	// memory map in sram words
	localparam sramAddr_t MENU_BASE   = 20'd0;
	localparam sramAddr_t BG_BASE     = 20'd256;
	localparam sramAddr_t SPRITE_BASE = 20'd512;

	localparam int FRAME_WORDS        = 192;
	localparam int SPRITE_WORDS       = 16;
	localparam int SPRITE_COUNT       = 8;
	localparam int WORDS_PER_ROW      = 4;
	localparam int SPRITE_STORE_WORDS = SPRITE_WORDS * SPRITE_COUNT;

	// sram control pins, all strobes active low
	typedef struct packed {
		logic      ce;
		logic      ub;
		logic      lb;
		logic      oe;
		logic      we;
		sramAddr_t addr;
	} sramPins_t;

	// travels with a read through the pipeline
	// index is wide enough for the frame store, sprite store uses the low bits
	typedef struct packed {
		logic      toSprite;
		frameIdx_t index;
	} readTag_t;

	// write command into the stores
	typedef struct packed {
		logic      valid;
		logic      toSprite;
		frameIdx_t index;
		sramWord_t data;
	} storeWrite_t;

endpackage

`default_nettype wire

// ==== src/sramReader.sv ====
`default_nettype none

module sramReader
	import drawPkg::*;
(
	input  logic        Clk,
	input  logic        arstN,
	input  logic        readReq,
	input  sramAddr_t   readAddr,
	input  readTag_t    readTag,
	input  sramWord_t   sramDataIn,
	output sramPins_t   sramPins,
	output storeWrite_t storeWr
);

	// stage 1 holds the tag of the read now on the pins
	logic      s1Valid;
	readTag_t  s1Tag;

	// stage 2 holds the captured word
	logic      s2Valid;
	readTag_t  s2Tag;
	sramWord_t s2Data;

	// control pins and valid bits
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			// chip idle, nothing in flight
			sramPins <= '{ce: 1'b1, ub: 1'b1, lb: 1'b1, oe: 1'b1, we: 1'b1, addr: '0};
			s1Valid  <= 1'b0;
			s2Valid  <= 1'b0;
		end
		else
		begin
			// enables follow the request one cycle late
			sramPins.ce <= ~readReq;
			sramPins.oe <= ~readReq;
			sramPins.ub <= ~readReq;
			sramPins.lb <= ~readReq;
			// read only, write enable stays high
			sramPins.we <= 1'b1;
			// hold the last address while idle
			if (readReq)
			begin
				sramPins.addr <= readAddr;
			end
			s1Valid <= readReq;
			s2Valid <= s1Valid;
		end
	end

	// payload, no reset needed
	always_ff @(posedge Clk)
	begin
		if (readReq)
		begin
			s1Tag <= readTag;
		end
		// data is sampled at the end of the cycle the address was on the pins
		if (s1Valid)
		begin
			s2Tag  <= s1Tag;
			s2Data <= sramDataIn;
		end
	end

	// write command toward the stores
	always_comb
	begin
		storeWr.valid    = s2Valid;
		storeWr.toSprite = s2Tag.toSprite;
		storeWr.index    = s2Tag.index;
		storeWr.data     = s2Data;
	end

endmodule

`default_nettype wire

// ==== src/loadSequencer.sv ====
`default_nettype none

module loadSequencer
	import drawPkg::*;
(
	input  logic        Clk,
	input  logic        arstN,
	input  logic        loadReq,
	input  gameState_t  gameState,
	input  storeWrite_t storeWrIn,
	output logic        readReq,
	output sramAddr_t   readAddr,
	output readTag_t    readTag,
	output storeWrite_t storeWrOut,
	output logic        busy,
	output logic        loadDone
);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		DRAIN
	} seqState_t;

	seqState_t state;
	loadKind_t kind;
	sramAddr_t base;
	frameIdx_t wordCnt;
	frameIdx_t lastIdx;
	logic      accept;
	logic      lastWrite;

	// game state decides what gets loaded
	function automatic loadKind_t kindOf(input gameState_t gs);
		case (gs)
			MENU:    return LOAD_MENU;
			PLAY:    return LOAD_BG;
			default: return LOAD_SPRITES;
		endcase
	endfunction

	function automatic sramAddr_t baseOf(input loadKind_t k);
		case (k)
			LOAD_MENU: return MENU_BASE;
			LOAD_BG:   return BG_BASE;
			default:   return SPRITE_BASE;
		endcase
	endfunction

	// last word index of the running load
	assign lastIdx = (kind == LOAD_SPRITES) ? frameIdx_t'(SPRITE_STORE_WORDS - 1)
	                                        : frameIdx_t'(FRAME_WORDS - 1);

	// busy covers the loadDone cycle too
	assign busy   = (state != IDLE) || loadDone;
	// requests during a load are dropped
	assign accept = loadReq && !busy;

	// final word coming back from the reader
	assign lastWrite = storeWrIn.valid && (storeWrIn.index == lastIdx);

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state    <= IDLE;
			kind     <= LOAD_MENU;
			base     <= '0;
			wordCnt  <= '0;
			loadDone <= 1'b0;
		end
		else
		begin
			// one cycle after the last store write
			loadDone <= (state == DRAIN) && lastWrite;
			case (state)
				IDLE:
				begin
					if (accept)
					begin
						kind    <= kindOf(gameState);
						base    <= baseOf(kindOf(gameState));
						wordCnt <= '0;
						state   <= ISSUE;
					end
				end
				ISSUE:
				begin
					// one read per cycle until the region is covered
					if (wordCnt == lastIdx)
					begin
						state <= DRAIN;
					end
					else
					begin
						wordCnt <= wordCnt + 8'd1;
					end
				end
				DRAIN:
				begin
					// two reads still in the reader pipeline
					if (lastWrite)
					begin
						state <= IDLE;
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// read request, address is base plus running word count
	assign readReq          = (state == ISSUE);
	assign readAddr         = base + sramAddr_t'(wordCnt);
	assign readTag.toSprite = (kind == LOAD_SPRITES);
	assign readTag.index    = wordCnt;

	// returned words go straight on to the stores
	assign storeWrOut = storeWrIn;

endmodule

`default_nettype wire

// ==== src/frameStore.sv ====
`default_nettype none

module frameStore
	import drawPkg::*;
(
	input  logic        Clk,
	input  logic        arstN,
	input  storeWrite_t storeWr,
	input  logic        rowReq,
	input  rowIdx_t     rowSel,
	output bgRow_t      bgRow,
	output logic        rowValid
);

	// one bit per pixel, 64 by 48 screen
	sramWord_t mem [FRAME_WORDS];
	frameIdx_t rowBase;

	// first word of the requested row
	assign rowBase = frameIdx_t'(rowSel) * frameIdx_t'(WORDS_PER_ROW);

	// word write port, frame writes only
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			// blank screen after reset
			for (int i = 0; i < FRAME_WORDS; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (storeWr.valid && !storeWr.toSprite)
		begin
			mem[storeWr.index] <= storeWr.data;
		end
	end

	// registered row read, strobe returns one cycle later
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			rowValid <= 1'b0;
			bgRow    <= '0;
		end
		else
		begin
			rowValid <= rowReq;
			if (rowReq)
			begin
				// lowest word lands in the low bits
				for (int w = 0; w < WORDS_PER_ROW; w++)
				begin
					bgRow[w*16 +: 16] <= mem[rowBase + frameIdx_t'(w)];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/spriteStore.sv ====
`default_nettype none

module spriteStore
	import drawPkg::*;
(
	input  logic        Clk,
	input  logic        arstN,
	input  storeWrite_t storeWr,
	input  spriteIdx_t  spriteSel,
	output sprite_t     bike
);

	// eight sprites of sixteen words each
	sramWord_t      mem [SPRITE_STORE_WORDS];
	spriteWordIdx_t wrIdx;
	spriteWordIdx_t selBase;

	// sprite writes only use the low index bits
	assign wrIdx = spriteWordIdx_t'(storeWr.index);

	// first word of the selected sprite
	assign selBase = spriteWordIdx_t'(spriteSel) * spriteWordIdx_t'(SPRITE_WORDS);

	// word write port
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < SPRITE_STORE_WORDS; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (storeWr.valid && storeWr.toSprite)
		begin
			mem[wrIdx] <= storeWr.data;
		end
	end

	// selected sprite is reloaded every cycle
	// so a new index shows up one cycle later
	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			bike <= '0;
		end
		else
		begin
			// word 0 is the top line, kept in the low bits
			for (int w = 0; w < SPRITE_WORDS; w++)
			begin
				bike[w*16 +: 16] <= mem[selBase + spriteWordIdx_t'(w)];
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/drawEngine.sv ====
`default_nettype none

module drawEngine
	import drawPkg::*;
(
	input  logic       Clk,
	input  logic       arstN,
	// load command
	input  logic       loadReq,
	input  gameState_t gameState,
	// display side
	input  logic       rowReq,
	input  rowIdx_t    rowSel,
	input  spriteIdx_t spriteSel,
	// sram
	input  sramWord_t  sramDataIn,
	output sramPins_t  sramPins,
	// status
	output logic       busy,
	output logic       loadDone,
	output bgRow_t     bgRow,
	output logic       rowValid,
	output sprite_t    bike
);

	// sequencer to reader
	logic        readReq;
	sramAddr_t   readAddr;
	readTag_t    readTag;
	// reader back to sequencer, then on to the stores
	storeWrite_t rdWr;
	storeWrite_t storeWr;

	loadSequencer i_loadSequencer (
		.Clk        (Clk),
		.arstN      (arstN),
		.loadReq    (loadReq),
		.gameState  (gameState),
		.storeWrIn  (rdWr),
		.readReq    (readReq),
		.readAddr   (readAddr),
		.readTag    (readTag),
		.storeWrOut (storeWr),
		.busy       (busy),
		.loadDone   (loadDone)
	);

	sramReader i_sramReader (
		.Clk        (Clk),
		.arstN      (arstN),
		.readReq    (readReq),
		.readAddr   (readAddr),
		.readTag    (readTag),
		.sramDataIn (sramDataIn),
		.sramPins   (sramPins),
		.storeWr    (rdWr)
	);

	// both stores see every write, each filters on toSprite
	frameStore i_frameStore (
		.Clk      (Clk),
		.arstN    (arstN),
		.storeWr  (storeWr),
		.rowReq   (rowReq),
		.rowSel   (rowSel),
		.bgRow    (bgRow),
		.rowValid (rowValid)
	);

	spriteStore i_spriteStore (
		.Clk       (Clk),
		.arstN     (arstN),
		.storeWr   (storeWr),
		.spriteSel (spriteSel),
		.bike      (bike)
	);

endmodule

`default_nettype wire

// ==== verification/sramModel.sv ====
`default_nettype none

// read-only model of an asynchronous 16-bit SRAM
// content is a fixed function of the word address, no storage needed
module sramModel
	import drawPkg::*;
(
	input  sramPins_t sramPins,
	output sramWord_t dataOut
);

	timeunit 1ns;
	timeprecision 100ps;

	// scrambled address, keeps neighbouring words distinct
	logic [31:0] product;
	sramWord_t   content;

	assign product = 32'(sramPins.addr) * 32'd40503;
	assign content = product[15:0] ^ 16'hA5C3;

	// data only while the chip is selected and output enabled
	// bus reads as zero otherwise
	always_comb
	begin
		if (!sramPins.ce && !sramPins.oe)
		begin
			dataOut = content;
		end
		else
		begin
			dataOut = '0;
		end
	end

endmodule

`default_nettype wire

// ==== verification/drawEngine_assert.sv ====
`default_nettype none

// protocol checks on the SRAM pins and the load status
module drawEngine_assert
	import drawPkg::*;
(
	input logic      Clk,
	input logic      arstN,
	input sramPins_t sramPins,
	input logic      loadDone,
	input logic      busy
);

	timeunit 1ns;
	timeprecision 100ps;

	// read-only engine, write enable never asserted
	weNeverLow: assert property (@(posedge Clk) disable iff (!arstN)
		sramPins.we)
		else $error("SRAM write enable driven low");

	// a selected chip always has its outputs enabled
	ceImpliesOe: assert property (@(posedge Clk) disable iff (!arstN)
		!sramPins.ce |-> !sramPins.oe)
		else $error("SRAM selected without output enable");

	// done is a single-cycle strobe
	loadDoneOneCycle: assert property (@(posedge Clk) disable iff (!arstN)
		loadDone |=> !loadDone)
		else $error("loadDone wider than one cycle");

	// busy drops only right after the done strobe
	busyFallsAfterDone: assert property (@(posedge Clk) disable iff (!arstN)
		$fell(busy) |-> $past(loadDone))
		else $error("busy fell without a preceding loadDone");

endmodule

bind drawEngine drawEngine_assert i_assert (
	.Clk      (Clk),
	.arstN    (arstN),
	.sramPins (sramPins),
	.loadDone (loadDone),
	.busy     (busy)
);

`default_nettype wire

// ==== verification/tbDrawEngine.sv ====
`default_nettype none

module tbDrawEngine
	import drawPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 4;
	// three frame loads (menu, background, ignored request) and one sprite load
	localparam int LOAD_CYCLES = 3 * (FRAME_WORDS + 3) + (SPRITE_COUNT * SPRITE_WORDS + 3);
	localparam int WATCHDOG_NS = 20 * LOAD_CYCLES * CLK_PERIOD;
	// generous bound for a single load
	localparam int LOAD_LIMIT = 2 * (FRAME_WORDS + 3);

	logic       Clk;
	logic       arstN;
	logic       loadReq;
	gameState_t gameState;
	logic       rowReq;
	rowIdx_t    rowSel;
	spriteIdx_t spriteSel;
	sramWord_t  sramDataIn;
	sramPins_t  sramPins;
	logic       busy;
	logic       loadDone;
	bgRow_t     bgRow;
	logic       rowValid;
	sprite_t    bike;

	int          errorCount;
	int          checkCount;
	int          testErrors;
	string       curTest;
	logic [31:0] rngState;

	drawEngine i_dut (
		.Clk        (Clk),
		.arstN      (arstN),
		.loadReq    (loadReq),
		.gameState  (gameState),
		.rowReq     (rowReq),
		.rowSel     (rowSel),
		.spriteSel  (spriteSel),
		.sramDataIn (sramDataIn),
		.sramPins   (sramPins),
		.busy       (busy),
		.loadDone   (loadDone),
		.bgRow      (bgRow),
		.rowValid   (rowValid),
		.bike       (bike)
	);

	sramModel i_sram (
		.sramPins (sramPins),
		.dataOut  (sramDataIn)
	);

	initial
	begin
		Clk = 1'b0;
		forever #(CLK_PERIOD / 2) Clk = ~Clk;
	end

	// ends a stuck run
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, simulation stopped", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	// SRAM content rule, low 16 bits of a * 40503 xor 0xA5C3
	function automatic sramWord_t expectedWord(input sramAddr_t a);
		logic [31:0] prod;
		prod = 32'(a) * 32'd40503;
		return prod[15:0] ^ 16'hA5C3;
	endfunction

	// four consecutive words, lowest address in the low bits
	function automatic bgRow_t expectedRow(input sramAddr_t base, input int row);
		bgRow_t r;
		for (int w = 0; w < WORDS_PER_ROW; w++)
		begin
			r[w*16 +: 16] = expectedWord(base + sramAddr_t'(row * WORDS_PER_ROW + w));
		end
		return r;
	endfunction

	function automatic sprite_t expectedSprite(input int idx);
		sprite_t s;
		for (int w = 0; w < SPRITE_WORDS; w++)
		begin
			s[w*16 +: 16] = expectedWord(SPRITE_BASE + sramAddr_t'(idx * SPRITE_WORDS + w));
		end
		return s;
	endfunction

	// xorshift32, advances the global state
	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// one clock, inputs may change right after return
	task automatic stepCycle();
		@(posedge Clk);
		#1;
	endtask

	task automatic checkBit(input string what, input logic exp, input logic act);
		checkCount++;
		if (act !== exp)
		begin
			errorCount++;
			$display("CHECK FAILED %s %s: expected %b, actual %b", curTest, what, exp, act);
		end
	endtask

	task automatic checkPins(input string what, input sramPins_t exp, input sramPins_t act);
		checkCount++;
		if (act !== exp)
		begin
			errorCount++;
			$display("CHECK FAILED %s %s: expected %h, actual %h", curTest, what, exp, act);
		end
	endtask

	task automatic checkRow(input string what, input bgRow_t exp, input bgRow_t act);
		checkCount++;
		if (act !== exp)
		begin
			errorCount++;
			$display("CHECK FAILED %s %s: expected %h, actual %h", curTest, what, exp, act);
		end
	endtask

	task automatic checkSprite(input string what, input sprite_t exp, input sprite_t act);
		checkCount++;
		if (act !== exp)
		begin
			errorCount++;
			$display("CHECK FAILED %s %s: expected %h, actual %h", curTest, what, exp, act);
		end
	endtask

	task automatic beginTest(input string name);
		curTest    = name;
		testErrors = errorCount;
	endtask

	task automatic endTest();
		if (errorCount == testErrors)
		begin
			$display("test %s: ok", curTest);
		end
		else
		begin
			$display("test %s: %0d errors", curTest, errorCount - testErrors);
		end
	endtask

	// single-cycle load strobe, busy must follow at once
	// and the first read reaches the pins one cycle later
	task automatic startLoad(input gameState_t gs, input sramAddr_t base);
		sramPins_t exp;
		gameState = gs;
		loadReq   = 1'b1;
		stepCycle();
		loadReq = 1'b0;
		checkBit("busy after loadReq", 1'b1, busy);
		// read cycle, every strobe low except write enable
		exp.ce   = 1'b0;
		exp.ub   = 1'b0;
		exp.lb   = 1'b0;
		exp.oe   = 1'b0;
		exp.we   = 1'b1;
		exp.addr = base;
		stepCycle();
		checkPins("sram pins on first read", exp, sramPins);
	endtask

	task automatic waitLoadDone();
		int n;
		n = 0;
		while (loadDone !== 1'b1 && n < LOAD_LIMIT)
		begin
			stepCycle();
			n++;
		end
		if (loadDone !== 1'b1)
		begin
			errorCount++;
			$display("%s: loadDone did not arrive within %0d cycles", curTest, LOAD_LIMIT);
		end
		else
		begin
			checkBit("busy during loadDone", 1'b1, busy);
			stepCycle();
			checkBit("busy after loadDone", 1'b0, busy);
		end
	endtask

	// request one row, result is due one cycle later
	task automatic readRow(input rowIdx_t r, input sramAddr_t base);
		rowSel = r;
		rowReq = 1'b1;
		stepCycle();
		rowReq = 1'b0;
		checkBit($sformatf("rowValid row %0d", r), 1'b1, rowValid);
		checkRow($sformatf("bgRow row %0d", r), expectedRow(base, int'(r)), bgRow);
	endtask

	task automatic readAllRows(input sramAddr_t base);
		for (int r = 0; r < FRAME_WORDS / WORDS_PER_ROW; r++)
		begin
			readRow(rowIdx_t'(r), base);
		end
	endtask

	task automatic testResetState();
		beginTest("reset state");
		checkBit("busy", 1'b0, busy);
		checkBit("loadDone", 1'b0, loadDone);
		checkBit("rowValid", 1'b0, rowValid);
		checkBit("sram ce", 1'b1, sramPins.ce);
		checkBit("sram oe", 1'b1, sramPins.oe);
		checkBit("sram we", 1'b1, sramPins.we);
		checkSprite("bike", '0, bike);
		endTest();
	endtask

	task automatic testMenuLoad();
		beginTest("menu load");
		startLoad(MENU, MENU_BASE);
		waitLoadDone();
		readAllRows(MENU_BASE);
		endTest();
	endtask

	// random rows, any menu leftover would show here
	task automatic testBackgroundLoad();
		rowIdx_t r;
		beginTest("background load");
		startLoad(PLAY, BG_BASE);
		waitLoadDone();
		for (int i = 0; i < 16; i++)
		begin
			r = rowIdx_t'(nextRandom() % 32'd48);
			readRow(r, BG_BASE);
		end
		endTest();
	endtask

	task automatic testSpriteLoad();
		beginTest("sprite load");
		startLoad(OVER, SPRITE_BASE);
		waitLoadDone();
		for (int s = 0; s < SPRITE_COUNT; s++)
		begin
			spriteSel = spriteIdx_t'(s);
			stepCycle();
			checkSprite($sformatf("bike %0d", s), expectedSprite(s), bike);
		end
		// frame store untouched by sprite writes
		readAllRows(BG_BASE);
		endTest();
	endtask

	// second strobe asks for the menu, which must never appear
	task automatic testIgnoredRequest();
		int doneSeen;
		beginTest("ignored request");
		doneSeen = 0;
		startLoad(PLAY, BG_BASE);
		repeat (20) stepCycle();
		gameState = MENU;
		loadReq   = 1'b1;
		stepCycle();
		loadReq = 1'b0;
		for (int n = 0; n < FRAME_WORDS + 40; n++)
		begin
			if (loadDone === 1'b1)
			begin
				doneSeen++;
			end
			stepCycle();
		end
		if (doneSeen != 1)
		begin
			errorCount++;
			$display("CHECK FAILED %s loadDone count: expected 1, actual %0d", curTest, doneSeen);
		end
		checkBit("busy after window", 1'b0, busy);
		readAllRows(BG_BASE);
		endTest();
	endtask

	// rowReq held high, one new row per cycle
	task automatic testBackToBackRows();
		rowIdx_t r;
		beginTest("back-to-back rows");
		rowReq = 1'b1;
		for (int i = 0; i < 12; i++)
		begin
			r      = rowIdx_t'(nextRandom() % 32'd48);
			rowSel = r;
			stepCycle();
			checkBit($sformatf("rowValid slot %0d", i), 1'b1, rowValid);
			checkRow($sformatf("bgRow slot %0d row %0d", i, r), expectedRow(BG_BASE, int'(r)),
				bgRow);
		end
		rowReq = 1'b0;
		stepCycle();
		checkBit("rowValid after last", 1'b0, rowValid);
		endTest();
	endtask

	initial
	begin
		errorCount = 0;
		checkCount = 0;
		testErrors = 0;
		curTest    = "";
		rngState   = 32'h4d7476a5;
		arstN      = 1'b0;
		loadReq    = 1'b0;
		gameState  = MENU;
		rowReq     = 1'b0;
		rowSel     = '0;
		spriteSel  = '0;

		repeat (4) @(posedge Clk);
		#1;
		arstN = 1'b1;
		stepCycle();

		testResetState();
		testMenuLoad();
		testBackgroundLoad();
		testSpriteLoad();
		testIgnoredRequest();
		testBackToBackRows();

		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("Test passed");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
src/drawPkg.sv
src/sramReader.sv
src/loadSequencer.sv
src/frameStore.sv
src/spriteStore.sv
src/drawEngine.sv
verification/sramModel.sv
verification/drawEngine_assert.sv
verification/tbDrawEngine.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tbDrawEngine
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || echo "Test failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
